/* build.f */
hw/lut_pkg.sv
hw/lut_fill_gen.sv
hw/lut_table_ram.sv
hw/lut_reader.sv
hw/bus_arbiter.sv
hw/lut_subsystem.sv
verif/lut_checker.sv
verif/tb_lut_subsystem.sv

/* hw/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter #(
   parameter int ext_addr_w = 16
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      req0,
   input  logic [ext_addr_w-1:0]     addr0,
   input  logic                      req1,
   input  logic [ext_addr_w-1:0]     addr1,
   input  logic                      mem_ack,
   input  logic [lut_pkg::bus_w-1:0] mem_rdata,
   output logic                      ack0,
   output logic [lut_pkg::bus_w-1:0] rdata0,
   output logic                      ack1,
   output logic [lut_pkg::bus_w-1:0] rdata1,
   output logic                      mem_req,
   output logic [ext_addr_w-1:0]     mem_addr
);

   // One-hot grant that is zero while the bus is free
   logic [1:0] grant;
   logic       last_served;
   logic       pick;
   logic       req_g;

   // Alternate on contention and otherwise take whoever asks
   always_comb begin
      if (req0 && req1) begin
         pick = ~last_served;
      end else begin
         pick = req1;
      end
   end

   assign req_g    = (grant[0] && req0) || (grant[1] && req1);
   assign mem_req  = req_g;
   assign mem_addr = grant[1] ? addr1 : addr0;

   assign ack0   = grant[0] && mem_ack;
   assign ack1   = grant[1] && mem_ack;
   assign rdata0 = mem_rdata;
   assign rdata1 = mem_rdata;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         grant       <= 2'b00;
         last_served <= 1'b1;
      end else if (grant == 2'b00) begin
         if (req0 || req1) begin
            grant       <= pick ? 2'b10 : 2'b01;
            last_served <= pick;
         end
      end else if (!req_g && !mem_ack) begin
         // Handshake fully returned to zero
         grant <= 2'b00;
      end
   end

   // An ack only reaches the master whose open request it answers
   assert property (@(posedge clk) disable iff (rst) $rose(mem_ack) |-> req_g)
      else $error("memory acknowledged with no granted request");

endmodule

/* hw/lut_fill_gen.sv */
`timescale 1ns/1ns

module lut_fill_gen #(
   parameter int addr_w     = 8,
   parameter int ext_addr_w = 16
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic                  next,
   input  logic [ext_addr_w-1:0] ext_addr,
   input  logic [addr_w-1:0]     int_addr,
   input  logic [addr_w-1:0]     incr,
   input  logic [addr_w-1:0]     count,
   output logic [ext_addr_w-1:0] gen_ext_addr,
   output logic [addr_w-1:0]     gen_int_addr,
   output logic                  gen_valid,
   output logic                  gen_last
);

   // Pairs still to hand out, current one included
   logic [addr_w-1:0] remaining;

   assign gen_last = gen_valid && (remaining == addr_w'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         gen_ext_addr <= '0;
         gen_int_addr <= '0;
         remaining    <= '0;
         gen_valid    <= 1'b0;
      end else if (start) begin
         gen_ext_addr <= ext_addr;
         gen_int_addr <= int_addr;
         remaining    <= count;
         // A zero count gives no pairs at all
         gen_valid    <= (count != '0);
      end else if (next) begin
         gen_ext_addr <= gen_ext_addr + ext_addr_w'(1);
         gen_int_addr <= gen_int_addr + incr;
         remaining    <= remaining - addr_w'(1);
         if (gen_last) begin
            gen_valid <= 1'b0;
         end
      end
   end

   // Consumer only steps a pair that exists
   assert property (@(posedge clk) disable iff (rst) next |-> gen_valid)
      else $error("fill generator stepped with no valid pair");

endmodule

/* hw/lut_pkg.sv */
package lut_pkg;

   // Lookup value width and external/table word width
   localparam int data_w = 32;
   localparam int bus_w = 64;

   // Lanes per word and the index bits that pick one
   localparam int lane_count = 2;
   localparam int lane_sel_w = $clog2(lane_count);

   // Bank used after reset and whenever ping-pong is off
   localparam logic bank_none = 1'b0;

   // One table word, seen whole or as its two lanes
   typedef union packed {
      logic [bus_w-1:0]                  raw;
      logic [lane_count-1:0][data_w-1:0] lanes;
   } lut_bus_word_u;

endpackage

/* hw/lut_reader.sv */
`timescale 1ns/1ns

module lut_reader #(
   parameter int addr_w     = 8,
   parameter int ext_addr_w = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       run,
   input  logic                       disabled,
   input  logic                       ping_pong,
   input  logic [ext_addr_w-1:0]      ext_addr,
   input  logic [addr_w-1:0]          int_addr,
   input  logic [addr_w-1:0]          incr,
   input  logic [addr_w-1:0]          count,
   input  logic [lut_pkg::data_w-1:0] index,
   input  logic                       bus_ack,
   input  logic [lut_pkg::bus_w-1:0]  bus_rdata,
   output logic [lut_pkg::data_w-1:0] out,
   output logic                       done,
   output logic                       bus_req,
   output logic [ext_addr_w-1:0]      bus_addr
);

   import lut_pkg::*;

   localparam logic [1:0] s_idle     = 2'd0;
   localparam logic [1:0] s_req      = 2'd1;
   localparam logic [1:0] s_wait_ack = 2'd2;
   localparam logic [1:0] s_wait_rel = 2'd3;

   logic [1:0]            state;
   logic                  fill_busy;
   logic                  fill_bank;
   logic                  run_ok;
   logic                  capture;
   logic [ext_addr_w-1:0] gen_ext_addr;
   logic [addr_w-1:0]     gen_int_addr;
   logic                  gen_valid;
   logic                  gen_last;
   logic                  wr_en;
   logic [addr_w-1:0]     wr_addr;
   logic [addr_w-1:0]     rd_addr;
   logic [addr_w-1:0]     word_addr;
   lut_bus_word_u         wr_word;
   lut_bus_word_u         rd_word;
   lut_bus_word_u         out_word;
   logic [lane_sel_w-1:0] lane_d1;
   logic [lane_sel_w-1:0] lane_d2;

   // Run only counts when enabled and no fill is pending
   assign run_ok  = run && !disabled && done;
   assign capture = (state == s_wait_ack) && bus_ack;

   lut_fill_gen #(
      .addr_w     (addr_w),
      .ext_addr_w (ext_addr_w)
   ) i_fill_gen (
      .clk          (clk),
      .rst          (rst),
      .start        (run_ok),
      .next         (capture),
      .ext_addr     (ext_addr),
      .int_addr     (int_addr),
      .incr         (incr),
      .count        (count),
      .gen_ext_addr (gen_ext_addr),
      .gen_int_addr (gen_int_addr),
      .gen_valid    (gen_valid),
      .gen_last     (gen_last)
   );

   assign bus_addr = gen_ext_addr;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state   <= s_idle;
         bus_req <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               if (fill_busy) begin
                  state <= s_req;
               end
            end
            s_req: begin
               if (gen_valid) begin
                  bus_req <= 1'b1;
                  state   <= s_wait_ack;
               end else begin
                  state <= s_idle;
               end
            end
            s_wait_ack: begin
               if (bus_ack) begin
                  bus_req <= 1'b0;
                  state   <= s_wait_rel;
               end
            end
            default: begin
               // Slave must drop ack before the next request
               if (!bus_ack) begin
                  state <= fill_busy ? s_req : s_idle;
               end
            end
         endcase
      end
   end

   // done rises one edge after the busy flag clears
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fill_busy <= 1'b0;
         done      <= 1'b1;
         fill_bank <= bank_none;
      end else begin
         if (run_ok) begin
            fill_busy <= 1'b1;
         end else if ((capture && gen_last) || (state == s_req && !gen_valid)) begin
            fill_busy <= 1'b0;
         end
         if (run_ok) begin
            done <= 1'b0;
         end else if (!fill_busy) begin
            done <= 1'b1;
         end
         // Banks swap as a ping-pong fill completes
         if (!ping_pong) begin
            fill_bank <= bank_none;
         end else if (!done && !fill_busy) begin
            fill_bank <= ~fill_bank;
         end
      end
   end

   assign wr_en       = capture;
   assign wr_word.raw = bus_rdata;
   assign wr_addr     = ping_pong ? {fill_bank, gen_int_addr[addr_w-2:0]} : gen_int_addr;

   assign word_addr = index[addr_w+lane_sel_w-1:lane_sel_w];
   assign rd_addr   = ping_pong ? {~fill_bank, word_addr[addr_w-2:0]} : word_addr;

   lut_table_ram #(
      .addr_w (addr_w)
   ) i_table_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_word),
      .rd_addr (rd_addr),
      .rd_data (rd_word)
   );

   // Lane select follows the RAM read and the output register
   always_ff @(posedge clk) begin
      lane_d1  <= index[lane_sel_w-1:0];
      lane_d2  <= lane_d1;
      out_word <= rd_word;
   end

   assign out = out_word.lanes[lane_d2];

   assert property (@(posedge clk) disable iff (rst)
      bus_req |=> (!bus_req || $stable(bus_addr)))
      else $error("bus address moved during a request");

   assert property (@(posedge clk) disable iff (rst) $fell(done) |-> $past(run))
      else $error("done fell without a run");

endmodule

/* hw/lut_subsystem.sv */
`timescale 1ns/1ns

module lut_subsystem #(
   parameter int addr_w     = 8,
   parameter int ext_addr_w = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       mem_ack,
   input  logic [lut_pkg::bus_w-1:0]  mem_rdata,
   output logic                       mem_req,
   output logic [ext_addr_w-1:0]      mem_addr,
   input  logic                       run0,
   input  logic                       disabled0,
   input  logic                       ping_pong0,
   input  logic [ext_addr_w-1:0]      ext_addr0,
   input  logic [addr_w-1:0]          int_addr0,
   input  logic [addr_w-1:0]          incr0,
   input  logic [addr_w-1:0]          count0,
   input  logic [lut_pkg::data_w-1:0] index0,
   output logic [lut_pkg::data_w-1:0] out0,
   output logic                       done0,
   input  logic                       run1,
   input  logic                       disabled1,
   input  logic                       ping_pong1,
   input  logic [ext_addr_w-1:0]      ext_addr1,
   input  logic [addr_w-1:0]          int_addr1,
   input  logic [addr_w-1:0]          incr1,
   input  logic [addr_w-1:0]          count1,
   input  logic [lut_pkg::data_w-1:0] index1,
   output logic [lut_pkg::data_w-1:0] out1,
   output logic                       done1
);

   import lut_pkg::*;

   // Reader to arbiter handshakes
   logic                  req0;
   logic                  req1;
   logic                  ack0;
   logic                  ack1;
   logic [ext_addr_w-1:0] addr0;
   logic [ext_addr_w-1:0] addr1;
   logic [bus_w-1:0]      rdata0;
   logic [bus_w-1:0]      rdata1;

   lut_reader #(
      .addr_w     (addr_w),
      .ext_addr_w (ext_addr_w)
   ) i_reader0 (
      .clk       (clk),
      .rst       (rst),
      .run       (run0),
      .disabled  (disabled0),
      .ping_pong (ping_pong0),
      .ext_addr  (ext_addr0),
      .int_addr  (int_addr0),
      .incr      (incr0),
      .count     (count0),
      .index     (index0),
      .bus_ack   (ack0),
      .bus_rdata (rdata0),
      .out       (out0),
      .done      (done0),
      .bus_req   (req0),
      .bus_addr  (addr0)
   );

   lut_reader #(
      .addr_w     (addr_w),
      .ext_addr_w (ext_addr_w)
   ) i_reader1 (
      .clk       (clk),
      .rst       (rst),
      .run       (run1),
      .disabled  (disabled1),
      .ping_pong (ping_pong1),
      .ext_addr  (ext_addr1),
      .int_addr  (int_addr1),
      .incr      (incr1),
      .count     (count1),
      .index     (index1),
      .bus_ack   (ack1),
      .bus_rdata (rdata1),
      .out       (out1),
      .done      (done1),
      .bus_req   (req1),
      .bus_addr  (addr1)
   );

   bus_arbiter #(
      .ext_addr_w (ext_addr_w)
   ) i_bus_arbiter (
      .clk       (clk),
      .rst       (rst),
      .req0      (req0),
      .addr0     (addr0),
      .req1      (req1),
      .addr1     (addr1),
      .mem_ack   (mem_ack),
      .mem_rdata (mem_rdata),
      .ack0      (ack0),
      .rdata0    (rdata0),
      .ack1      (ack1),
      .rdata1    (rdata1),
      .mem_req   (mem_req),
      .mem_addr  (mem_addr)
   );

endmodule

/* hw/lut_table_ram.sv */
`timescale 1ns/1ns

module lut_table_ram #(
   parameter int addr_w = 8
) (
   input  logic                  clk,
   input  logic                  wr_en,
   input  logic [addr_w-1:0]     wr_addr,
   input  lut_pkg::lut_bus_word_u wr_data,
   input  logic [addr_w-1:0]     rd_addr,
   output lut_pkg::lut_bus_word_u rd_data
);

   import lut_pkg::*;

   localparam int depth = 2 ** addr_w;

   lut_bus_word_u mem [depth];

   // Fill side
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Lookup side, one cycle of latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* verif/lut_checker.sv */
`timescale 1ns/1ns

module lut_checker #(
   parameter int addr_w     = 8,
   parameter int ext_addr_w = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       mem_req,
   input  logic                       exp_bank,
   input  logic                       look_en0,
   input  logic                       look_en1,
   input  logic                       run0,
   input  logic                       disabled0,
   input  logic                       ping_pong0,
   input  logic [ext_addr_w-1:0]      ext_addr0,
   input  logic [addr_w-1:0]          int_addr0,
   input  logic [addr_w-1:0]          incr0,
   input  logic [addr_w-1:0]          count0,
   input  logic [lut_pkg::data_w-1:0] index0,
   input  logic [lut_pkg::data_w-1:0] out0,
   input  logic                       done0,
   input  logic                       run1,
   input  logic                       disabled1,
   input  logic                       ping_pong1,
   input  logic [ext_addr_w-1:0]      ext_addr1,
   input  logic [addr_w-1:0]          int_addr1,
   input  logic [addr_w-1:0]          incr1,
   input  logic [addr_w-1:0]          count1,
   input  logic [lut_pkg::data_w-1:0] index1,
   input  logic [lut_pkg::data_w-1:0] out1,
   input  logic                       done1,
   output int                         lookups,
   output int                         value_errs,
   output int                         done_errs,
   output int                         bus_errs
);

   import lut_pkg::*;

   localparam int depth = 2 ** addr_w;

   // Expected table image holding the external address of each word
   logic [ext_addr_w-1:0] img_ext [2][depth];
   logic                  img_ok  [2][depth];

   // Two lookups in flight per unit
   logic                  pipe_on  [2][2];
   logic [data_w-1:0]     pipe_exp [2][2];
   logic [data_w-1:0]     pipe_idx [2][2];
   logic                  want_low [2];
   int                    quiet    [2];

   // Upper half is the address and the lower half its complement
   function automatic logic [bus_w-1:0] mem_word(input logic [ext_addr_w-1:0] a);
      return {data_w'(a), ~data_w'(a)};
   endfunction

   task automatic watch_unit(
      input int                    u,
      input logic                  run,
      input logic                  dis,
      input logic                  pp,
      input logic [ext_addr_w-1:0] ext,
      input logic [addr_w-1:0]     start,
      input logic [addr_w-1:0]     incr,
      input logic [addr_w-1:0]     count,
      input logic                  look,
      input logic [data_w-1:0]     index,
      input logic                  done,
      input logic [data_w-1:0]     out
   );
      logic [addr_w-1:0] a;
      logic [addr_w-1:0] word;
      lut_bus_word_u     w;
      int                k;
      // Lookup sampled two edges ago is on out now
      if (pipe_on[u][1]) begin
         lookups++;
         if (out !== pipe_exp[u][1]) begin
            value_errs++;
            $display("** Error: %0t ns unit %0d index %h gave %h, expected %h",
                     $time, u, pipe_idx[u][1], out, pipe_exp[u][1]);
         end
      end
      pipe_on[u][1]  = pipe_on[u][0];
      pipe_exp[u][1] = pipe_exp[u][0];
      pipe_idx[u][1] = pipe_idx[u][0];
      pipe_on[u][0]  = 1'b0;
      if (look) begin
         word = index[addr_w:1];
         // Read side of a ping-pong unit sees one bank only
         if (pp) begin
            word[addr_w-1] = exp_bank;
         end
         if (!img_ok[u][word]) begin
            value_errs++;
            $display("Lookup on unit %0d reads table word %h, which no fill has written",
                     u, word);
         end else begin
            w.raw          = mem_word(img_ext[u][word]);
            pipe_on[u][0]  = 1'b1;
            pipe_exp[u][0] = w.lanes[index[0]];
            pipe_idx[u][0] = index;
         end
      end
      if (want_low[u] && done) begin
         done_errs++;
         $display("** Error: %0t ns unit %0d done still high after an accepted run", $time, u);
      end
      if (quiet[u] > 0) begin
         if (!done) begin
            done_errs++;
            $display("** Error: %0t ns unit %0d done low after a disabled run", $time, u);
         end
         if (mem_req) begin
            bus_errs++;
            $display("** Error: %0t ns mem_req high after a disabled run on unit %0d",
                     $time, u);
         end
         quiet[u]--;
      end
      want_low[u] = run && !dis;
      if (run && dis) begin
         quiet[u] = 20;
      end
      if (run && !dis) begin
         a = start;
         for (k = 0; k < int'(count); k++) begin
            word = a;
            if (pp) begin
               word[addr_w-1] = exp_bank;
            end
            img_ext[u][word] = ext + ext_addr_w'(k);
            img_ok[u][word]  = 1'b1;
            a = a + incr;
         end
      end
   endtask

   always @(posedge clk or posedge rst) begin : watch
      int i;
      int j;
      if (rst) begin
         lookups    = 0;
         value_errs = 0;
         done_errs  = 0;
         bus_errs   = 0;
         for (i = 0; i < 2; i++) begin
            want_low[i] = 1'b0;
            quiet[i]    = 0;
            pipe_on[i][0] = 1'b0;
            pipe_on[i][1] = 1'b0;
            for (j = 0; j < depth; j++) begin
               img_ok[i][j] = 1'b0;
            end
         end
      end else begin
         watch_unit(0, run0, disabled0, ping_pong0, ext_addr0, int_addr0, incr0, count0,
                    look_en0, index0, done0, out0);
         watch_unit(1, run1, disabled1, ping_pong1, ext_addr1, int_addr1, incr1, count1,
                    look_en1, index1, done1, out1);
      end
   end

endmodule

/* verif/tb_lut_subsystem.sv */
`timescale 1ns/1ns

module tb_lut_subsystem;

   import lut_pkg::*;

   localparam int addr_w     = 8;
   localparam int ext_addr_w = 16;

   localparam logic [1:0] op_idle = 2'd0;
   localparam logic [1:0] op_run  = 2'd1;
   localparam logic [1:0] op_look = 2'd2;

   // One table row per applied step
   typedef struct packed {
      logic [1:0]            op;
      logic [1:0]            mask;
      logic                  dis;
      logic                  pp;
      logic [ext_addr_w-1:0] ext_a;
      logic [ext_addr_w-1:0] ext_b;
      logic [addr_w-1:0]     int_a;
      logic [addr_w-1:0]     incr;
      logic [addr_w-1:0]     count;
      logic [data_w-1:0]     index;
      logic                  bank;
      logic                  wait_done;
      logic [7:0]            gap;
   } row_t;

   row_t rows [$];

   logic clk = 1'b0;
   logic rst;
   logic mem_req;
   logic mem_ack;
   logic [ext_addr_w-1:0] mem_addr;
   logic [bus_w-1:0]      mem_rdata;
   logic run0, disabled0, ping_pong0, done0;
   logic run1, disabled1, ping_pong1, done1;
   logic [ext_addr_w-1:0] ext_addr0, ext_addr1;
   logic [addr_w-1:0]     int_addr0, int_addr1, incr0, incr1, count0, count1;
   logic [data_w-1:0]     index0, index1, out0, out1;
   logic look_en0, look_en1, exp_bank;
   logic        pending;
   int          delay;
   logic [31:0] lfsr;
   int cycle_count = 0;
   int cycle_limit = 0;
   int lookups, value_errs, done_errs, bus_errs;

   always #50 clk = ~clk;

   lut_subsystem #(
      .addr_w     (addr_w),
      .ext_addr_w (ext_addr_w)
   ) i_lut_subsystem (
      .clk (clk), .rst (rst), .mem_ack (mem_ack), .mem_rdata (mem_rdata),
      .mem_req (mem_req), .mem_addr (mem_addr),
      .run0 (run0), .disabled0 (disabled0), .ping_pong0 (ping_pong0),
      .ext_addr0 (ext_addr0), .int_addr0 (int_addr0), .incr0 (incr0),
      .count0 (count0), .index0 (index0), .out0 (out0), .done0 (done0),
      .run1 (run1), .disabled1 (disabled1), .ping_pong1 (ping_pong1),
      .ext_addr1 (ext_addr1), .int_addr1 (int_addr1), .incr1 (incr1),
      .count1 (count1), .index1 (index1), .out1 (out1), .done1 (done1)
   );

   lut_checker #(
      .addr_w     (addr_w),
      .ext_addr_w (ext_addr_w)
   ) i_lut_checker (
      .clk (clk), .rst (rst), .mem_req (mem_req), .exp_bank (exp_bank),
      .look_en0 (look_en0), .look_en1 (look_en1),
      .run0 (run0), .disabled0 (disabled0), .ping_pong0 (ping_pong0),
      .ext_addr0 (ext_addr0), .int_addr0 (int_addr0), .incr0 (incr0),
      .count0 (count0), .index0 (index0), .out0 (out0), .done0 (done0),
      .run1 (run1), .disabled1 (disabled1), .ping_pong1 (ping_pong1),
      .ext_addr1 (ext_addr1), .int_addr1 (int_addr1), .incr1 (incr1),
      .count1 (count1), .index1 (index1), .out1 (out1), .done1 (done1),
      .lookups (lookups), .value_errs (value_errs), .done_errs (done_errs),
      .bus_errs (bus_errs)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [bus_w-1:0] mem_word(input logic [ext_addr_w-1:0] a);
      return {data_w'(a), ~data_w'(a)};
   endfunction

   // Memory model, one word per four-phase transfer, 1 to 3 cycles to answer
   always @(posedge clk or posedge rst) begin : mem_model
      logic [31:0] s;
      logic [1:0]  draw;
      if (rst) begin
         mem_ack   <= 1'b0;
         mem_rdata <= '0;
         pending   <= 1'b0;
         delay     <= 0;
         lfsr      <= 32'hc0309cdc;
      end else if (mem_ack) begin
         if (!mem_req) begin
            mem_ack <= 1'b0;
         end
      end else if (mem_req) begin
         if (!pending) begin
            s       = lfsr_next(lfsr);
            draw[0] = s[0];
            s       = lfsr_next(s);
            draw[1] = s[0];
            lfsr    <= s;
            pending <= 1'b1;
            delay   <= int'(draw % 2'd3) + 1;
         end else if (delay <= 1) begin
            mem_ack   <= 1'b1;
            mem_rdata <= mem_word(mem_addr);
            pending   <= 1'b0;
         end else begin
            delay <= delay - 1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: stimulus still running after %0d cycles", cycle_count);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   function automatic row_t run_row(
      input logic [1:0] mask, input logic dis, input logic pp,
      input logic [ext_addr_w-1:0] ext_a, input logic [ext_addr_w-1:0] ext_b,
      input logic [addr_w-1:0] int_a, input logic [addr_w-1:0] incr,
      input logic [addr_w-1:0] count, input logic bank, input logic wait_done);
      row_t r;
      r           = '0;
      r.op        = op_run;
      r.mask      = mask;
      r.dis       = dis;
      r.pp        = pp;
      r.ext_a     = ext_a;
      r.ext_b     = ext_b;
      r.int_a     = int_a;
      r.incr      = incr;
      r.count     = count;
      r.bank      = bank;
      r.wait_done = wait_done;
      return r;
   endfunction

   function automatic row_t look_row(
      input logic [1:0] mask, input logic pp, input logic [data_w-1:0] index,
      input logic bank);
      row_t r;
      r       = '0;
      r.op    = op_look;
      r.mask  = mask;
      r.pp    = pp;
      r.index = index;
      r.bank  = bank;
      return r;
   endfunction

   function automatic row_t idle_row(input logic [1:0] mask, input logic [7:0] gap);
      row_t r;
      r           = '0;
      r.op        = op_idle;
      r.mask      = mask;
      r.wait_done = 1'b1;
      r.gap       = gap;
      return r;
   endfunction

   task automatic build_table();
      // Unit 0, 16 words with incr 1, both lanes
      rows.push_back(run_row(2'b01, 1'b0, 1'b0, 16'h0100, 16'h0000, 8'h00, 8'd1, 8'd16,
                             1'b0, 1'b1));
      rows.push_back(look_row(2'b01, 1'b0, 32'h00, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h01, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h02, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h03, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h1e, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h1f, 1'b0));
      // Both units in the same cycle from different regions
      rows.push_back(run_row(2'b11, 1'b0, 1'b0, 16'h0200, 16'h0300, 8'h20, 8'd1, 8'd8,
                             1'b0, 1'b1));
      rows.push_back(look_row(2'b01, 1'b0, 32'h40, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h4f, 1'b0));
      rows.push_back(look_row(2'b10, 1'b0, 32'h40, 1'b0));
      rows.push_back(look_row(2'b10, 1'b0, 32'h4f, 1'b0));
      rows.push_back(look_row(2'b11, 1'b0, 32'h41, 1'b0));
      // Stride 2 leaves odd words from the first fill
      rows.push_back(run_row(2'b01, 1'b0, 1'b0, 16'h0400, 16'h0000, 8'h00, 8'd2, 8'd8,
                             1'b0, 1'b1));
      rows.push_back(look_row(2'b01, 1'b0, 32'h02, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h03, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h04, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h1d, 1'b0));
      rows.push_back(look_row(2'b01, 1'b0, 32'h1f, 1'b0));
      // Ping-pong on unit 1, first image lands in bank 0
      rows.push_back(run_row(2'b10, 1'b0, 1'b1, 16'h0000, 16'h0500, 8'h10, 8'd1, 8'd8,
                             1'b0, 1'b1));
      rows.push_back(look_row(2'b10, 1'b1, 32'h20, 1'b0));
      rows.push_back(look_row(2'b10, 1'b1, 32'h2f, 1'b0));
      // Second image into bank 1, reads stay on bank 0 meanwhile
      rows.push_back(run_row(2'b10, 1'b0, 1'b1, 16'h0000, 16'h0600, 8'h10, 8'd1, 8'd8,
                             1'b1, 1'b0));
      rows.push_back(look_row(2'b10, 1'b1, 32'h21, 1'b0));
      rows.push_back(look_row(2'b10, 1'b1, 32'h2e, 1'b0));
      rows.push_back(look_row(2'b10, 1'b1, 32'h2f, 1'b0));
      rows.push_back(idle_row(2'b10, 8'd0));
      rows.push_back(look_row(2'b10, 1'b1, 32'h20, 1'b1));
      rows.push_back(look_row(2'b10, 1'b1, 32'h21, 1'b1));
      rows.push_back(look_row(2'b10, 1'b1, 32'h2f, 1'b1));
      // Disabled unit must stay quiet
      rows.push_back(run_row(2'b01, 1'b1, 1'b0, 16'h0700, 16'h0000, 8'h00, 8'd1, 8'd4,
                             1'b0, 1'b1));
      rows.push_back(idle_row(2'b01, 8'd22));
      rows.push_back(look_row(2'b01, 1'b0, 32'h04, 1'b0));
   endtask

   task automatic apply_row(input row_t r);
      if (r.op != op_idle) begin
         exp_bank <= r.bank;
      end
      if (r.mask[0] && r.op != op_idle) begin
         ping_pong0 <= r.pp;
         if (r.op == op_run) begin
            run0      <= 1'b1;
            disabled0 <= r.dis;
            ext_addr0 <= r.ext_a;
            int_addr0 <= r.int_a;
            incr0     <= r.incr;
            count0    <= r.count;
         end else begin
            look_en0 <= 1'b1;
            index0   <= r.index;
         end
      end
      if (r.mask[1] && r.op != op_idle) begin
         ping_pong1 <= r.pp;
         if (r.op == op_run) begin
            run1      <= 1'b1;
            disabled1 <= r.dis;
            ext_addr1 <= r.ext_b;
            int_addr1 <= r.int_a;
            incr1     <= r.incr;
            count1    <= r.count;
         end else begin
            look_en1 <= 1'b1;
            index1   <= r.index;
         end
      end
   endtask

   task automatic clear_pulses();
      run0     <= 1'b0;
      run1     <= 1'b0;
      look_en0 <= 1'b0;
      look_en1 <= 1'b0;
   endtask

   task automatic wait_for_done(input logic [1:0] mask);
      @(posedge clk);
      while (!((!mask[0] || done0) && (!mask[1] || done1))) begin
         @(posedge clk);
      end
   endtask

   initial begin
      int n_looks;
      n_looks = 0;
      build_table();
      cycle_limit = 400 * rows.size() + 100;
      rst        <= 1'b1;
      exp_bank   <= 1'b0;
      disabled0  <= 1'b0;
      disabled1  <= 1'b0;
      ping_pong0 <= 1'b0;
      ping_pong1 <= 1'b0;
      ext_addr0  <= '0;
      ext_addr1  <= '0;
      int_addr0  <= '0;
      int_addr1  <= '0;
      incr0      <= '0;
      incr1      <= '0;
      count0     <= '0;
      count1     <= '0;
      index0     <= '0;
      index1     <= '0;
      clear_pulses();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      foreach (rows[i]) begin
         clear_pulses();
         apply_row(rows[i]);
         if (rows[i].op == op_look) begin
            n_looks += rows[i].mask[0] + rows[i].mask[1];
         end
         @(posedge clk);
         if (rows[i].wait_done || rows[i].gap != 0) begin
            clear_pulses();
            if (rows[i].wait_done) begin
               wait_for_done(rows[i].mask);
            end
            repeat (rows[i].gap) @(posedge clk);
         end
      end
      clear_pulses();
      // Let the last lookups drain
      repeat (4) @(posedge clk);
      if (lookups != n_looks) begin
         $display("Only %0d of %0d lookups reached a comparison", lookups, n_looks);
      end
      $display("Summary: %0d lookups, %0d value errors, %0d done errors, %0d bus errors",
               lookups, value_errs, done_errs, bus_errs);
      if (value_errs + done_errs + bus_errs == 0 && lookups == n_looks) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
